/* rtl/pole_fir_pkg.sv */
package pole_fir_pkg;

    // Sample format, eight samples per clock
    localparam int NSAMP = 8;
    localparam int NBITS = 16;
    localparam int NFRAC = 2;

    // Coefficient format
    localparam int CBITS = 18;
    localparam int CFRAC = 14;

    // Accumulator format used by both chains and the outputs
    localparam int ACC_BITS = 48;
    localparam int ACC_FRAC = 27;

    // Sum operand fed back into the tail and cross multipliers
    localparam int TRUNC_BITS = 30;
    localparam int TRUNC_FRAC = 13;
    localparam int TRUNC_LSB = ACC_FRAC - TRUNC_FRAC;

    // Shifts that put samples and products on the accumulator binary point
    localparam int SAMPLE_SHIFT = ACC_FRAC - NFRAC;
    localparam int PROD_SHIFT = ACC_FRAC - NFRAC - CFRAC;

    // Samples 2 to 7 in f, sample 0 plus samples 2 to 7 in g
    localparam int F_TAPS = NSAMP - 2;
    localparam int G_TAPS = NSAMP - 1;

    // Head to tail of one chain, then the cross-link, then the whole path
    localparam int CHAIN_LAT = 9;
    localparam int XLINK_LAT = 3;
    localparam int TOTAL_LAT = 1 + CHAIN_LAT + XLINK_LAT;

    typedef logic signed [NBITS-1:0] sample_t;
    typedef logic signed [CBITS-1:0] coeff_t;
    typedef logic signed [ACC_BITS-1:0] acc_t;

    // Coefficient write targets
    typedef enum logic [1:0] {
        ADR_F_CHAIN = 2'b00,
        ADR_G_CHAIN = 2'b01,
        ADR_F_CROSS = 2'b10,
        ADR_G_CROSS = 2'b11
    } coeff_adr_e;

    // Sample moved onto the accumulator point
    function automatic acc_t scale_sample(sample_t s);
        acc_t r;
        r = s;
        return r <<< SAMPLE_SHIFT;
    endfunction

    // Full precision sample times coefficient
    function automatic acc_t mul_sample(sample_t s, coeff_t c);
        logic signed [NBITS+CBITS-1:0] p;
        acc_t r;
        p = s * c;
        r = p;
        return r <<< PROD_SHIFT;
    endfunction

    // Low bits of the sum dropped before the multiply
    function automatic acc_t mul_sum(acc_t a, coeff_t c);
        logic signed [TRUNC_BITS-1:0] t;
        acc_t p;
        t = a[TRUNC_LSB +: TRUNC_BITS];
        p = t * c;
        return p;
    endfunction

endpackage

/* rtl/coeff_bus_if.sv */
`timescale 1ns/10ps

interface coeff_bus_if;
    import pole_fir_pkg::*;

    // Coefficient word, registered alongside the strobes
    coeff_t data;

    // One shift strobe per target, at most one high
    logic   f_shift;
    logic   g_shift;
    logic   fx_shift;
    logic   gx_shift;

    // Copies every shadow register into its active register
    logic   update;

    modport src (output data, output f_shift, output g_shift,
                 output fx_shift, output gx_shift, output update);

    modport f_chain (input data, input f_shift, input update);

    modport g_chain (input data, input g_shift, input update);

    modport xlink (input data, input fx_shift, input gx_shift, input update);

endinterface

/* rtl/coeff_ctrl.sv */
`timescale 1ns/10ps

module coeff_ctrl (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  pole_fir_pkg::coeff_adr_e coeff_adr_i,
    input  logic                     coeff_wr_i,
    input  logic                     coeff_update_i,
    input  pole_fir_pkg::coeff_t     coeff_dat_i,
    coeff_bus_if.src                 bus
);
    import pole_fir_pkg::*;

    // Address decode into one registered strobe per target
    // Data and update go through one register too, so all stay in step
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bus.data     <= '0;
            bus.f_shift  <= 1'b0;
            bus.g_shift  <= 1'b0;
            bus.fx_shift <= 1'b0;
            bus.gx_shift <= 1'b0;
            bus.update   <= 1'b0;
        end else begin
            bus.data     <= coeff_dat_i;
            // Chain shadow registers
            bus.f_shift  <= coeff_wr_i && (coeff_adr_i == ADR_F_CHAIN);
            bus.g_shift  <= coeff_wr_i && (coeff_adr_i == ADR_G_CHAIN);
            // Cross-link shadow registers
            bus.fx_shift <= coeff_wr_i && (coeff_adr_i == ADR_F_CROSS);
            bus.gx_shift <= coeff_wr_i && (coeff_adr_i == ADR_G_CROSS);
            bus.update   <= coeff_update_i;
        end
    end

    // Only one shadow chain may move per write
    a_one_shift : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        $onehot0({bus.f_shift, bus.g_shift, bus.fx_shift, bus.gx_shift})
    );

endmodule

/* rtl/sample_delay_line.sv */
`timescale 1ns/10ps

module sample_delay_line (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  pole_fir_pkg::sample_t dat_i [pole_fir_pkg::NSAMP],
    output pole_fir_pkg::sample_t f_tap_o [pole_fir_pkg::F_TAPS],
    output pole_fir_pkg::sample_t g_tap_o [pole_fir_pkg::G_TAPS],
    output pole_fir_pkg::sample_t head_f_o,
    output pole_fir_pkg::sample_t head_g_o,
    output pole_fir_pkg::sample_t x_o [pole_fir_pkg::NSAMP]
);
    import pole_fir_pkg::*;

    sample_t aligned [NSAMP];
    sample_t head_q;

    // Sample k waits k clocks, samples 0 and 1 go straight through
    for (genvar k = 0; k < NSAMP; k++) begin : g_smp
        if (k < 2) begin : g_direct
            assign aligned[k] = dat_i[k];
        end else begin : g_delay
            sample_t [k-1:0] sr_q;
            always_ff @(posedge clk or negedge arst_n_i) begin
                if (!arst_n_i) begin
                    sr_q <= '0;
                end else begin
                    sr_q[0] <= dat_i[k];
                    for (int i = 1; i < k; i++) begin
                        sr_q[i] <= sr_q[i-1];
                    end
                end
            end
            assign aligned[k] = sr_q[k-1];
        end
        assign x_o[k] = aligned[k];
    end

    // Sample 0 one clock late so it meets sample 2 at the f head
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            head_q <= '0;
        end else begin
            head_q <= dat_i[0];
        end
    end

    assign head_f_o = head_q;
    assign head_g_o = dat_i[1];

    // One delay per sample feeds both chains
    assign g_tap_o[0] = dat_i[0];
    for (genvar t = 0; t < F_TAPS; t++) begin : g_tap
        assign f_tap_o[t]   = aligned[t+2];
        assign g_tap_o[t+1] = aligned[t+2];
    end

    a_x2_delay : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        $past(arst_n_i, 2) && $past(arst_n_i) |-> x_o[2] == $past(dat_i[2], 2)
    );

endmodule

/* rtl/mac_chain.sv */
`timescale 1ns/10ps

module mac_chain #(
    parameter int NTAPS = pole_fir_pkg::F_TAPS
) (
    input  logic                  clk,
    input  logic                  arst_n_i,
    coeff_bus_if                  coeff,
    input  pole_fir_pkg::sample_t base_i,
    input  pole_fir_pkg::sample_t tap_i [NTAPS],
    output pole_fir_pkg::acc_t    chain_sum_o,
    output pole_fir_pkg::acc_t    tail_sum_o
);
    import pole_fir_pkg::*;

    // Registers left over after the tap stages and the two tail stages
    localparam int PAD = CHAIN_LAT - NTAPS - 2;

    logic             shift;
    // Index 0 is the head coefficient, index NTAPS the tail
    coeff_t [NTAPS:0] shd_q;
    coeff_t [NTAPS:0] act_q;
    // One partial sum per tap stage
    acc_t [NTAPS-1:0] acc_q;
    acc_t             chain_sum;
    acc_t             tsum_q;
    acc_t             tprod_q;
    acc_t             tail_q;

    // The f chain shifts on f_shift, the g chain on g_shift
    if (NTAPS == F_TAPS) begin : g_f_role
        assign shift = coeff.f_shift;
    end else begin : g_g_role
        assign shift = coeff.g_shift;
    end

    // Shadow registers shift head to tail
    // First word written lands on the tail
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            shd_q <= '0;
            act_q <= '0;
        end else begin
            if (shift) begin
                shd_q[0] <= coeff.data;
                for (int i = 1; i <= NTAPS; i++) begin
                    shd_q[i] <= shd_q[i-1];
                end
            end
            // Old shadow values are captured on the update edge
            if (coeff.update) begin
                act_q <= shd_q;
            end
        end
    end

    // Systolic accumulate
    // Tap j arrives j clocks after tap 0, the delay line staggers them
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            acc_q <= '0;
        end else begin
            // Head adds the scaled base sample to the first product
            acc_q[0] <= scale_sample(base_i) + mul_sample(tap_i[0], act_q[0]);
            for (int j = 1; j < NTAPS; j++) begin
                acc_q[j] <= acc_q[j-1] + mul_sample(tap_i[j], act_q[j]);
            end
        end
    end

    // Padding so both tap counts reach the tail after CHAIN_LAT clocks
    if (PAD > 0) begin : g_pad
        acc_t [PAD-1:0] pad_q;
        always_ff @(posedge clk or negedge arst_n_i) begin
            if (!arst_n_i) begin
                pad_q <= '0;
            end else begin
                pad_q[0] <= acc_q[NTAPS-1];
                for (int p = 1; p < PAD; p++) begin
                    pad_q[p] <= pad_q[p-1];
                end
            end
        end
        assign chain_sum = pad_q[PAD-1];
    end else if (PAD == 0) begin : g_no_pad
        assign chain_sum = acc_q[NTAPS-1];
    end else begin : g_too_long
        $error("mac_chain: NTAPS %0d does not fit in CHAIN_LAT", NTAPS);
    end

    // Tail stage, sum plus tail coefficient times the truncated sum
    // Multiply and sum copy in one clock, the add in the next
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tsum_q  <= '0;
            tprod_q <= '0;
            tail_q  <= '0;
        end else begin
            tsum_q  <= chain_sum;
            tprod_q <= mul_sum(chain_sum, act_q[NTAPS]);
            tail_q  <= tsum_q + tprod_q;
        end
    end

    assign chain_sum_o = chain_sum;
    assign tail_sum_o  = tail_q;

    // New coefficients only appear right after an update strobe
    a_act_on_update : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (act_q != $past(act_q)) |-> $past(coeff.update)
    );

endmodule

/* rtl/cross_link.sv */
`timescale 1ns/10ps

module cross_link (
    input  logic               clk,
    input  logic               arst_n_i,
    coeff_bus_if.xlink         coeff,
    input  pole_fir_pkg::acc_t f_sum_i,
    input  pole_fir_pkg::acc_t f_tail_i,
    input  pole_fir_pkg::acc_t g_sum_i,
    input  pole_fir_pkg::acc_t g_tail_i,
    output pole_fir_pkg::acc_t y0_o,
    output pole_fir_pkg::acc_t y1_o
);
    import pole_fir_pkg::*;

    // Side 0 builds y0 from F and g
    // Side 1 builds y1 from G and f
    logic   shift [2];
    acc_t   own_tail [2];
    acc_t   partner_sum [2];
    coeff_t shd_q [2];
    coeff_t act_q [2];
    acc_t   sum_q [2];
    acc_t   prod_q [2];
    acc_t   tail_q [2][XLINK_LAT-1];
    acc_t   y_q [2];

    assign shift[0]       = coeff.fx_shift;
    assign shift[1]       = coeff.gx_shift;
    assign own_tail[0]    = f_tail_i;
    assign own_tail[1]    = g_tail_i;
    assign partner_sum[0] = g_sum_i;
    assign partner_sum[1] = f_sum_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 2; i++) begin
                shd_q[i]  <= '0;
                act_q[i]  <= '0;
                sum_q[i]  <= '0;
                prod_q[i] <= '0;
                tail_q[i] <= '{default: '0};
                y_q[i]    <= '0;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                // XF and XG each hold a single shadow word
                if (shift[i]) begin
                    shd_q[i] <= coeff.data;
                end
                if (coeff.update) begin
                    act_q[i] <= shd_q[i];
                end
                // Partner sum path, input register then multiply register
                sum_q[i]  <= partner_sum[i];
                prod_q[i] <= mul_sum(sum_q[i], act_q[i]);
                // Own tail waits for the product
                tail_q[i][0] <= own_tail[i];
                for (int s = 1; s < XLINK_LAT-1; s++) begin
                    tail_q[i][s] <= tail_q[i][s-1];
                end
                y_q[i] <= tail_q[i][XLINK_LAT-2] + prod_q[i];
            end
        end
    end

    assign y0_o = y_q[0];
    assign y1_o = y_q[1];

endmodule

/* rtl/pole_fir.sv */
`timescale 1ns/10ps

module pole_fir (
    input  logic                                                    clk,
    input  logic                                                    arst_n_i,
    input  logic [pole_fir_pkg::NSAMP*pole_fir_pkg::NBITS-1:0]      dat_i,
    // 00 f chain, 01 g chain, 10 f cross-link, 11 g cross-link
    input  logic [1:0]                                              coeff_adr_i,
    input  logic                                                    coeff_wr_i,
    input  logic                                                    coeff_update_i,
    input  logic [pole_fir_pkg::CBITS-1:0]                          coeff_dat_i,
    output logic [pole_fir_pkg::ACC_BITS-1:0]                       y0_o,
    output logic [pole_fir_pkg::ACC_BITS-1:0]                       y1_o,
    // Sample k delayed by k clocks, for the incremental stage
    output logic [pole_fir_pkg::NSAMP*pole_fir_pkg::NBITS-1:0]      x_o
);
    import pole_fir_pkg::*;

    sample_t dat [NSAMP];
    sample_t x_dly [NSAMP];
    sample_t f_tap [F_TAPS];
    sample_t g_tap [G_TAPS];
    sample_t head_f;
    sample_t head_g;
    acc_t    f_sum;
    acc_t    f_tail;
    acc_t    g_sum;
    acc_t    g_tail;

    coeff_bus_if coeff_bus ();

    // Flat vectors to sample arrays and back
    for (genvar k = 0; k < NSAMP; k++) begin : g_unpack
        assign dat[k]                 = dat_i[k*NBITS +: NBITS];
        assign x_o[k*NBITS +: NBITS]  = x_dly[k];
    end

    coeff_ctrl u_coeff_ctrl (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .coeff_adr_i    (coeff_adr_e'(coeff_adr_i)),
        .coeff_wr_i     (coeff_wr_i),
        .coeff_update_i (coeff_update_i),
        .coeff_dat_i    (coeff_dat_i),
        .bus            (coeff_bus.src)
    );

    sample_delay_line u_delay (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .dat_i    (dat),
        .f_tap_o  (f_tap),
        .g_tap_o  (g_tap),
        .head_f_o (head_f),
        .head_g_o (head_g),
        .x_o      (x_dly)
    );

    // f starts one clock later, g has one more tap
    mac_chain #(.NTAPS(F_TAPS)) u_f_chain (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .coeff       (coeff_bus.f_chain),
        .base_i      (head_f),
        .tap_i       (f_tap),
        .chain_sum_o (f_sum),
        .tail_sum_o  (f_tail)
    );

    mac_chain #(.NTAPS(G_TAPS)) u_g_chain (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .coeff       (coeff_bus.g_chain),
        .base_i      (head_g),
        .tap_i       (g_tap),
        .chain_sum_o (g_sum),
        .tail_sum_o  (g_tail)
    );

    cross_link u_xlink (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .coeff    (coeff_bus.xlink),
        .f_sum_i  (f_sum),
        .f_tail_i (f_tail),
        .g_sum_i  (g_sum),
        .g_tail_i (g_tail),
        .y0_o     (y0_o),
        .y1_o     (y1_o)
    );

endmodule

/* bench/pole_fir_tb.sv */
`timescale 1ns/10ps

module pole_fir_tb;
    import pole_fir_pkg::*;

    // Outputs must hold still at least the path latency, then agree within a margin
    localparam int SETTLE_MIN = TOTAL_LAT + 2;
    localparam int SETTLE_MAX = TOTAL_LAT + 12;

    logic                   clk = 1'b0;
    logic                   arst_n_i;
    logic [NSAMP*NBITS-1:0] dat_i;
    logic [1:0]             coeff_adr_i;
    logic                   coeff_wr_i;
    logic                   coeff_update_i;
    logic [CBITS-1:0]       coeff_dat_i;
    logic [ACC_BITS-1:0]    y0_o;
    logic [ACC_BITS-1:0]    y1_o;
    logic [NSAMP*NBITS-1:0] x_o;

    // Shadow contents as written, index 0 is the head word
    coeff_t                 cf [F_TAPS+1];
    coeff_t                 cg [G_TAPS+1];
    coeff_t                 xf;
    coeff_t                 xg;
    // Constant input vector of the steady-state tests
    logic [NSAMP*NBITS-1:0] hold_smp;
    logic [ACC_BITS-1:0]    exp_y0;
    logic [ACC_BITS-1:0]    exp_y1;
    // Entry j holds the input vector from j+1 clocks back
    logic [NSAMP*NBITS-1:0] dat_hist [NSAMP];
    logic                   y_chk_en;
    logic                   x_chk_en;
    string                  test_name;
    integer                 seed;

    pole_fir DUT (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .dat_i          (dat_i),
        .coeff_adr_i    (coeff_adr_i),
        .coeff_wr_i     (coeff_wr_i),
        .coeff_update_i (coeff_update_i),
        .coeff_dat_i    (coeff_dat_i),
        .y0_o           (y0_o),
        .y1_o           (y1_o),
        .x_o            (x_o)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        dat_hist[0] <= dat_i;
        for (int i = 1; i < NSAMP; i++) begin
            dat_hist[i] <= dat_hist[i-1];
        end
    end

    task automatic report_mismatch(input string what, input logic [63:0] expv,
                                   input logic [63:0] actv);
        $display("FAIL %s %s expected %0h actual %0h", test_name, what, expv, actv);
        $display("Errors found");
        $fatal(1);
    endtask

    // Sample moved from 2 to 27 fractional bits
    function automatic longint on_acc_point(sample_t s);
        return longint'(s) <<< (ACC_FRAC - NFRAC);
    endfunction

    // Full product has 2 + 14 fractional bits
    function automatic longint sample_times_coeff(sample_t s, coeff_t c);
        return (longint'(s) * longint'(c)) <<< (ACC_FRAC - NFRAC - CFRAC);
    endfunction

    // Sum cut down to 13 fractional bits, so 13 + 14 lands on 27
    function automatic longint sum_times_coeff(longint a, coeff_t c);
        return (a >>> (ACC_FRAC - TRUNC_FRAC)) * longint'(c);
    endfunction

    function automatic logic [NSAMP*NBITS-1:0] random_vector();
        logic [NSAMP*NBITS-1:0] v;
        // Small samples keep every sum far from wrap
        for (int k = 0; k < NSAMP; k++) begin
            v[k*NBITS +: NBITS] = NBITS'($random(seed) % 256);
        end
        return v;
    endfunction

    function automatic coeff_t random_coeff();
        return coeff_t'($random(seed) % 8192);
    endfunction

    // Golden steady state from the held inputs and the updated coefficients
    task automatic compute_expected();
        sample_t u [NSAMP];
        longint  f;
        longint  g;
        longint  big_f;
        longint  big_g;
        for (int k = 0; k < NSAMP; k++) begin
            u[k] = hold_smp[k*NBITS +: NBITS];
        end
        f = on_acc_point(u[0]);
        for (int k = 0; k < F_TAPS; k++) begin
            f += sample_times_coeff(u[k+2], cf[k]);
        end
        big_f = f + sum_times_coeff(f, cf[F_TAPS]);
        g = on_acc_point(u[1]) + sample_times_coeff(u[0], cg[0]);
        for (int k = 1; k < G_TAPS; k++) begin
            g += sample_times_coeff(u[k+1], cg[k]);
        end
        big_g = g + sum_times_coeff(g, cg[G_TAPS]);
        // Each output takes the partner's pre-tail sum
        exp_y0 = ACC_BITS'(big_f + sum_times_coeff(g, xf));
        exp_y1 = ACC_BITS'(big_g + sum_times_coeff(f, xg));
    endtask

    task automatic wait_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
        end
    endtask

    // One write strobe, the model shifts head to tail like the shadow chain
    task automatic write_coeff(input coeff_adr_e adr, input coeff_t val);
        @(posedge clk);
        coeff_adr_i <= adr;
        coeff_wr_i  <= 1'b1;
        coeff_dat_i <= val;
        @(posedge clk);
        coeff_wr_i  <= 1'b0;
        case (adr)
            ADR_F_CHAIN: begin
                for (int i = F_TAPS; i > 0; i--) begin
                    cf[i] = cf[i-1];
                end
                cf[0] = val;
            end
            ADR_G_CHAIN: begin
                for (int i = G_TAPS; i > 0; i--) begin
                    cg[i] = cg[i-1];
                end
                cg[0] = val;
            end
            ADR_F_CROSS: xf = val;
            ADR_G_CROSS: xg = val;
        endcase
    endtask

    // Checks pause while the pipeline moves to the new coefficients
    task automatic pulse_update();
        y_chk_en = 1'b0;
        @(posedge clk);
        coeff_update_i <= 1'b1;
        @(posedge clk);
        coeff_update_i <= 1'b0;
        compute_expected();
    endtask

    // Sampled on the falling edge, away from the register updates
    task automatic wait_settled();
        int cnt;
        cnt = 0;
        while (cnt < SETTLE_MIN || y0_o != exp_y0 || y1_o != exp_y1) begin
            if (cnt >= SETTLE_MAX) begin
                $display("Timeout in %s, outputs did not settle in %0d cycles", test_name, cnt);
                if (y0_o != exp_y0) begin
                    report_mismatch("y0", 64'(exp_y0), 64'(y0_o));
                end else begin
                    report_mismatch("y1", 64'(exp_y1), 64'(y1_o));
                end
            end else begin
                @(negedge clk);
                cnt++;
            end
        end
        y_chk_en = 1'b1;
    endtask

    a_y0 : assert property (@(posedge clk) disable iff (!y_chk_en) y0_o == exp_y0)
        else report_mismatch("y0", 64'($sampled(exp_y0)), 64'($sampled(y0_o)));

    a_y1 : assert property (@(posedge clk) disable iff (!y_chk_en) y1_o == exp_y1)
        else report_mismatch("y1", 64'($sampled(exp_y1)), 64'($sampled(y1_o)));

    // Sample k of x_o against input sample k from k clocks back
    for (genvar k = 0; k < NSAMP; k++) begin : g_x_check
        if (k < 2) begin : g_direct
            a_x : assert property (@(posedge clk) disable iff (!x_chk_en)
                x_o[k*NBITS +: NBITS] == dat_i[k*NBITS +: NBITS])
                else report_mismatch("x_o", 64'($sampled(dat_i[k*NBITS +: NBITS])),
                                     64'($sampled(x_o[k*NBITS +: NBITS])));
        end else begin : g_delayed
            a_x : assert property (@(posedge clk) disable iff (!x_chk_en)
                x_o[k*NBITS +: NBITS] == dat_hist[k-1][k*NBITS +: NBITS])
                else report_mismatch("x_o", 64'($sampled(dat_hist[k-1][k*NBITS +: NBITS])),
                                     64'($sampled(x_o[k*NBITS +: NBITS])));
        end
    end

    initial begin
        seed           = 32'h6466;
        arst_n_i       = 1'b0;
        dat_i          = '0;
        coeff_adr_i    = '0;
        coeff_wr_i     = 1'b0;
        coeff_update_i = 1'b0;
        coeff_dat_i    = '0;
        y_chk_en       = 1'b0;
        x_chk_en       = 1'b0;
        xf             = '0;
        xg             = '0;
        cf             = '{default: '0};
        cg             = '{default: '0};
        test_name      = "reset_state";
        wait_cycles(4);
        arst_n_i <= 1'b1;

        // Zero coefficients, so y0 is u0 and y1 is u1
        hold_smp = random_vector();
        @(posedge clk);
        dat_i <= hold_smp;
        compute_expected();
        wait_settled();
        wait_cycles(TOTAL_LAT);

        // New random vector every clock, x_o checked once history is full
        test_name = "delayed_vector";
        y_chk_en  = 1'b0;
        for (int n = 0; n < 40; n++) begin
            @(posedge clk);
            dat_i <= random_vector();
            if (n == NSAMP) begin
                x_chk_en = 1'b1;
            end
        end
        hold_smp = random_vector();
        @(posedge clk);
        dat_i <= hold_smp;
        compute_expected();
        wait_settled();

        // Shadow loads alone leave y unchanged, tail word goes in first
        test_name = "chain_update";
        for (int k = F_TAPS; k >= 0; k--) begin
            write_coeff(ADR_F_CHAIN, random_coeff());
        end
        for (int k = G_TAPS; k >= 0; k--) begin
            write_coeff(ADR_G_CHAIN, random_coeff());
        end
        wait_cycles(TOTAL_LAT);
        pulse_update();
        wait_settled();
        wait_cycles(TOTAL_LAT);

        test_name = "cross_link";
        write_coeff(ADR_F_CROSS, random_coeff());
        write_coeff(ADR_G_CROSS, random_coeff());
        wait_cycles(4);
        pulse_update();
        wait_settled();
        wait_cycles(TOTAL_LAT);

        // One nonzero word then zeros, only the tail coefficient survives
        test_name = "shift_order";
        write_coeff(ADR_F_CHAIN, coeff_t'(18'sd4096));
        for (int k = 0; k < F_TAPS; k++) begin
            write_coeff(ADR_F_CHAIN, '0);
        end
        pulse_update();
        wait_settled();
        wait_cycles(TOTAL_LAT);

        $display("No errors");
        $finish;
    end

endmodule

/* project.f */
rtl/pole_fir_pkg.sv
rtl/coeff_bus_if.sv
rtl/coeff_ctrl.sv
rtl/sample_delay_line.sv
rtl/mac_chain.sv
rtl/cross_link.sv
rtl/pole_fir.sv
bench/pole_fir_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the pole FIR testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module pole_fir_tb -f project.f

# A failing check ends the simulation with a nonzero status, the search decides
sim_out=$(./obj_dir/Vpole_fir_tb 2>&1 || true)
echo "$sim_out"

if grep -q "No errors" <<< "$sim_out"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
